// ==== verilog/mpa_pkg.sv ====
// MPA core shared definitions
// Word and register types, memory sizes, MIPS opcode and function codes,
// back-door target encoding, ALU and writeback selects, decoded control word
package mpa_pkg;

   // Datapath widths
   localparam int WORD_W    = 32;
   localparam int REG_AW    = 5;
   localparam int REG_COUNT = 32;

   // Both memories hold 64 words
   localparam int IMEM_DEPTH = 64;
   localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
   localparam int DMEM_DEPTH = 64;
   localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_AW-1:0] reg_addr_t;

   // Opcode field, instr[31:26]
   localparam logic [5:0] OP_SPECIAL = 6'h00;
   localparam logic [5:0] OP_LUI     = 6'h0f;
   localparam logic [5:0] OP_LW      = 6'h23;
   localparam logic [5:0] OP_LBU     = 6'h24;
   localparam logic [5:0] OP_LHU     = 6'h25;

   // Function field for OP_SPECIAL, instr[5:0]
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUBU = 6'h23;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_XOR  = 6'h26;
   localparam logic [5:0] FN_NOR  = 6'h27;

   // Encoding of the debug_func pins
   typedef enum logic [1:0] {
      TGT_NONE = 2'd0,
      TGT_IMEM = 2'd1,
      TGT_DMEM = 2'd2,
      TGT_REGS = 2'd3
   } debug_target_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR
   } alu_op_t;

   // Source of a register write, NONE means no write
   typedef enum logic [2:0] {
      WB_NONE, WB_ALU, WB_UPPER_IMM, WB_LOAD_BYTE, WB_LOAD_HALF, WB_LOAD_WORD
   } wb_sel_t;

   typedef struct packed {
      alu_op_t alu_op;
      wb_sel_t wb_sel;
      logic    dst_is_rd;  // Write rd, else rt
      logic    b_is_imm;   // Operand b from sign-extended immediate
   } ctrl_t;

endpackage

// ==== verilog/mpa_debug_if.sv ====
// MPA back-door bus
// One-word accesses from the debug port into instruction memory,
// data memory and the register file while the core is halted
interface mpa_debug_if;

   // Copy of mem_debug, core halted while high
   logic          halt;
   mpa_pkg::word_t addr;
   mpa_pkg::word_t wdata;
   logic          we;

   // Per-target selects, at most one high
   logic          im_sel;
   logic          dm_sel;
   logic          mr_sel;

   // Read data, combinational from addr
   mpa_pkg::word_t im_rdata;
   mpa_pkg::word_t dm_rdata;
   mpa_pkg::word_t mr_rdata;

   modport ctrl (output halt, addr, wdata, we, im_sel, dm_sel, mr_sel,
                 input  im_rdata, dm_rdata, mr_rdata);

   modport imem (input halt, addr, wdata, we, im_sel, output im_rdata);

   modport dmem (input halt, addr, wdata, we, dm_sel, output dm_rdata);

   modport regs (input halt, addr, wdata, we, mr_sel, output mr_rdata);

endinterface

// ==== verilog/mpa_debug_port.sv ====
// MPA back-door port
// Turns debug_func into one target select while halted, forwards address,
// write data and write enable, and captures read data onto dout
module mpa_debug_port (
   input  logic           HW_RSTn,
   input  logic           mem_debug_clk_gate,
   input  logic           mem_debug,
   input  logic [1:0]     debug_func,
   input  logic           debug_we,
   input  logic           debug_re,
   input  mpa_pkg::word_t addr,
   input  mpa_pkg::word_t din,
   output mpa_pkg::word_t dout,
   mpa_debug_if.ctrl      dbg
);

   mpa_pkg::debug_target_t tgt;
   mpa_pkg::word_t         rd_word;

   assign tgt = mpa_pkg::debug_target_t'(debug_func);

   // Bus fields pass through unqualified
   assign dbg.halt  = mem_debug;
   assign dbg.addr  = addr;
   assign dbg.wdata = din;
   assign dbg.we    = debug_we;

   // Selects only during halt
   assign dbg.im_sel = mem_debug && (tgt == mpa_pkg::TGT_IMEM);
   assign dbg.dm_sel = mem_debug && (tgt == mpa_pkg::TGT_DMEM);
   assign dbg.mr_sel = mem_debug && (tgt == mpa_pkg::TGT_REGS);

   // Read mux, TGT_NONE reads zero
   always_comb begin
      case (tgt)
         mpa_pkg::TGT_IMEM: rd_word = dbg.im_rdata;
         mpa_pkg::TGT_DMEM: rd_word = dbg.dm_rdata;
         mpa_pkg::TGT_REGS: rd_word = dbg.mr_rdata;
         default:           rd_word = '0;
      endcase
   end

   // dout holds until the next halted read
   always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
      if (!HW_RSTn) begin
         dout <= '0;
      end else if (mem_debug && debug_re) begin
         dout <= rd_word;
      end
   end

   // Back-door strobes are dropped while the core runs
   a_access_halted: assert property (@(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
      (debug_we || debug_re) |-> mem_debug);

endmodule

// ==== verilog/mpa_fetch.sv ====
// MPA instruction fetch
// Program counter plus 64-word instruction memory. PC steps once per
// clock while running, back door loads and reads words during halt
module mpa_fetch (
   input  logic           HW_RSTn,
   input  logic           mem_debug_clk_gate,
   mpa_debug_if.imem      dbg,
   output mpa_pkg::word_t instr
);

   mpa_pkg::word_t                  imem [mpa_pkg::IMEM_DEPTH];
   logic [mpa_pkg::IMEM_AW-1:0]     pc;

   // Back-door write, word index from addr low bits
   always_ff @(posedge mem_debug_clk_gate) begin
      if (dbg.im_sel && dbg.we) begin
         imem[dbg.addr[mpa_pkg::IMEM_AW-1:0]] <= dbg.wdata;
      end
   end

   assign dbg.im_rdata = imem[dbg.addr[mpa_pkg::IMEM_AW-1:0]];

   // PC wraps naturally at IMEM_DEPTH
   always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
      if (!HW_RSTn) begin
         pc <= '0;
      end else if (!dbg.halt) begin
         pc <= pc + 1'b1;
      end
   end

   assign instr = imem[pc];

   // Running core fetches only loaded program words
   a_instr_known: assert property (@(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
      !dbg.halt |-> !$isunknown(instr));

endmodule

// ==== verilog/mpa_decoder.sv ====
// MPA instruction decoder
// Combinational control for the kept MIPS subset: R-type ADDU, SUBU,
// AND, OR, XOR, NOR plus LUI, LBU, LHU, LW. Unknown encodings write nothing
module mpa_decoder (
   input  mpa_pkg::word_t instr,
   output mpa_pkg::ctrl_t ctrl
);

   logic [5:0] opcode;
   logic [5:0] funct;

   assign opcode = instr[31:26];
   assign funct  = instr[5:0];

   always_comb begin
      // Default is a no-op
      ctrl.alu_op    = mpa_pkg::ALU_ADD;
      ctrl.wb_sel    = mpa_pkg::WB_NONE;
      ctrl.dst_is_rd = 1'b0;
      ctrl.b_is_imm  = 1'b0;

      case (opcode)
         mpa_pkg::OP_SPECIAL: begin
            // R-type writes rd from the ALU
            ctrl.dst_is_rd = 1'b1;
            ctrl.wb_sel    = mpa_pkg::WB_ALU;
            case (funct)
               mpa_pkg::FN_ADDU: ctrl.alu_op = mpa_pkg::ALU_ADD;
               mpa_pkg::FN_SUBU: ctrl.alu_op = mpa_pkg::ALU_SUB;
               mpa_pkg::FN_AND:  ctrl.alu_op = mpa_pkg::ALU_AND;
               mpa_pkg::FN_OR:   ctrl.alu_op = mpa_pkg::ALU_OR;
               mpa_pkg::FN_XOR:  ctrl.alu_op = mpa_pkg::ALU_XOR;
               mpa_pkg::FN_NOR:  ctrl.alu_op = mpa_pkg::ALU_NOR;
               // All-zero word lands here
               default:          ctrl.wb_sel = mpa_pkg::WB_NONE;
            endcase
         end
         mpa_pkg::OP_LUI: begin
            ctrl.wb_sel = mpa_pkg::WB_UPPER_IMM;
         end
         // Loads compute rs + imm in the ALU
         mpa_pkg::OP_LBU: begin
            ctrl.b_is_imm = 1'b1;
            ctrl.wb_sel   = mpa_pkg::WB_LOAD_BYTE;
         end
         mpa_pkg::OP_LHU: begin
            ctrl.b_is_imm = 1'b1;
            ctrl.wb_sel   = mpa_pkg::WB_LOAD_HALF;
         end
         mpa_pkg::OP_LW: begin
            ctrl.b_is_imm = 1'b1;
            ctrl.wb_sel   = mpa_pkg::WB_LOAD_WORD;
         end
         default: begin
            ctrl.wb_sel = mpa_pkg::WB_NONE;
         end
      endcase
   end

endmodule

// ==== verilog/mpa_reg_file.sv ====
// MPA register file
// 32 x 32-bit registers, register 0 fixed at zero. Two read ports for
// rs and rt, one write port shared by writeback and the back door
module mpa_reg_file (
   input  logic           HW_RSTn,
   input  logic           mem_debug_clk_gate,
   mpa_debug_if.regs      dbg,
   input  mpa_pkg::word_t instr,
   input  mpa_pkg::ctrl_t ctrl,
   input  mpa_pkg::word_t alu_result,
   input  mpa_pkg::word_t load_data,
   output mpa_pkg::word_t rs_data,
   output mpa_pkg::word_t rt_data
);

   mpa_pkg::word_t     regs [mpa_pkg::REG_COUNT];
   mpa_pkg::reg_addr_t rs;
   mpa_pkg::reg_addr_t rt;
   mpa_pkg::reg_addr_t dst;
   mpa_pkg::reg_addr_t dbg_reg;
   mpa_pkg::word_t     wb_data;
   logic               core_we;

   assign rs      = instr[25:21];
   assign rt      = instr[20:16];
   assign dst     = ctrl.dst_is_rd ? instr[15:11] : rt;
   assign dbg_reg = dbg.addr[mpa_pkg::REG_AW-1:0];

   // Writeback source
   always_comb begin
      case (ctrl.wb_sel)
         mpa_pkg::WB_ALU:       wb_data = alu_result;
         mpa_pkg::WB_UPPER_IMM: wb_data = {instr[15:0], 16'h0000};
         mpa_pkg::WB_LOAD_BYTE,
         mpa_pkg::WB_LOAD_HALF,
         mpa_pkg::WB_LOAD_WORD: wb_data = load_data;
         default:               wb_data = '0;
      endcase
   end

   assign core_we = !dbg.halt && (ctrl.wb_sel != mpa_pkg::WB_NONE);

   // Register 0 is cleared by reset and never written
   always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
      if (!HW_RSTn) begin
         for (int i = 0; i < mpa_pkg::REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (core_we) begin
         if (dst != '0) begin
            regs[dst] <= wb_data;
         end
      end else if (dbg.mr_sel && dbg.we && (dbg_reg != '0)) begin
         regs[dbg_reg] <= dbg.wdata;
      end
   end

   assign rs_data      = regs[rs];
   assign rt_data      = regs[rt];
   assign dbg.mr_rdata = regs[dbg_reg];

endmodule

// ==== verilog/mpa_alu.sv ====
// MPA ALU
// Add, subtract and bitwise ops on rs and either rt or the
// sign-extended immediate
module mpa_alu (
   input  mpa_pkg::word_t instr,
   input  mpa_pkg::word_t rs_data,
   input  mpa_pkg::word_t rt_data,
   input  mpa_pkg::ctrl_t ctrl,
   output mpa_pkg::word_t result
);

   mpa_pkg::word_t imm_ext;
   mpa_pkg::word_t b;

   assign imm_ext = {{16{instr[15]}}, instr[15:0]};
   assign b       = ctrl.b_is_imm ? imm_ext : rt_data;

   // Wrapping arithmetic, no overflow trap
   always_comb begin
      case (ctrl.alu_op)
         mpa_pkg::ALU_ADD: result = rs_data + b;
         mpa_pkg::ALU_SUB: result = rs_data - b;
         mpa_pkg::ALU_AND: result = rs_data & b;
         mpa_pkg::ALU_OR:  result = rs_data | b;
         mpa_pkg::ALU_XOR: result = rs_data ^ b;
         mpa_pkg::ALU_NOR: result = ~(rs_data | b);
         default:          result = '0;
      endcase
   end

endmodule

// ==== verilog/mpa_data_mem.sv ====
// MPA data memory
// 64 words, byte addressed through bits 7:2 for both the core load path
// and the back door. Loads pick and zero-extend the byte or half lane
module mpa_data_mem (
   input  logic           mem_debug_clk_gate,
   mpa_debug_if.dmem      dbg,
   input  mpa_pkg::word_t addr,
   input  mpa_pkg::ctrl_t ctrl,
   output mpa_pkg::word_t load_data
);

   mpa_pkg::word_t dmem [mpa_pkg::DMEM_DEPTH];
   mpa_pkg::word_t word;

   // Back-door write, byte address like the core
   always_ff @(posedge mem_debug_clk_gate) begin
      if (dbg.dm_sel && dbg.we) begin
         dmem[dbg.addr[mpa_pkg::DMEM_AW+1:2]] <= dbg.wdata;
      end
   end

   assign dbg.dm_rdata = dmem[dbg.addr[mpa_pkg::DMEM_AW+1:2]];

   assign word = dmem[addr[mpa_pkg::DMEM_AW+1:2]];

   // Lane extraction
   always_comb begin
      case (ctrl.wb_sel)
         mpa_pkg::WB_LOAD_BYTE: load_data = {24'h0, word[{addr[1:0], 3'b000} +: 8]};
         mpa_pkg::WB_LOAD_HALF: load_data = {16'h0, word[{addr[1], 4'b0000} +: 16]};
         default:               load_data = word;
      endcase
   end

   // Halfword loads need an even address
   a_half_align: assert property (@(posedge mem_debug_clk_gate)
      (!dbg.halt && ctrl.wb_sel == mpa_pkg::WB_LOAD_HALF) |-> (addr[0] == 1'b0));

endmodule

// ==== verilog/mpa_core_top.sv ====
// MPA single-cycle core, top level
// Debug port, fetch, decoder, register file, ALU and data memory.
// Core halted while mem_debug is high, back door then reaches all storage
module mpa_core_top (
   input  logic           HW_RSTn,
   input  logic           mem_debug_clk_gate,
   input  logic           mem_debug,
   input  logic [1:0]     debug_func,
   input  logic           debug_we,
   input  logic           debug_re,
   input  mpa_pkg::word_t addr,
   input  mpa_pkg::word_t din,
   output mpa_pkg::word_t dout
);

   mpa_pkg::word_t instr;
   mpa_pkg::ctrl_t ctrl;
   mpa_pkg::word_t rs_data;
   mpa_pkg::word_t rt_data;
   mpa_pkg::word_t alu_result;
   mpa_pkg::word_t load_data;

   // Shared back-door bus
   mpa_debug_if dbg_if ();

   mpa_debug_port debug_port_i (
      .HW_RSTn            (HW_RSTn),
      .mem_debug_clk_gate (mem_debug_clk_gate),
      .mem_debug          (mem_debug),
      .debug_func         (debug_func),
      .debug_we           (debug_we),
      .debug_re           (debug_re),
      .addr               (addr),
      .din                (din),
      .dout               (dout),
      .dbg                (dbg_if.ctrl)
   );

   mpa_fetch fetch_i (
      .HW_RSTn            (HW_RSTn),
      .mem_debug_clk_gate (mem_debug_clk_gate),
      .dbg                (dbg_if.imem),
      .instr              (instr)
   );

   mpa_decoder decoder_i (
      .instr (instr),
      .ctrl  (ctrl)
   );

   mpa_reg_file reg_file_i (
      .HW_RSTn            (HW_RSTn),
      .mem_debug_clk_gate (mem_debug_clk_gate),
      .dbg                (dbg_if.regs),
      .instr              (instr),
      .ctrl               (ctrl),
      .alu_result         (alu_result),
      .load_data          (load_data),
      .rs_data            (rs_data),
      .rt_data            (rt_data)
   );

   mpa_alu alu_i (
      .instr   (instr),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .ctrl    (ctrl),
      .result  (alu_result)
   );

   // Load address comes straight from the ALU
   mpa_data_mem data_mem_i (
      .mem_debug_clk_gate (mem_debug_clk_gate),
      .dbg                (dbg_if.dmem),
      .addr               (alu_result),
      .ctrl               (ctrl),
      .load_data          (load_data)
   );

endmodule

// ==== tb/mpa_tb.sv ====
// MPA core testbench
// Replays back-door writes, run phases and read-back checks from the
// case file against the core top level
module mpa_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam time CLK_PERIOD = 100ns;
   localparam int  MAX_STEPS  = 4000;
   localparam int  MAX_CHARS  = 200;
   localparam int  MAX_RUN    = 64;
   localparam int  MAX_CYCLES = 2000;
   localparam int  READ_LAT   = 1;

   logic           HW_RSTn;
   logic           mem_debug_clk_gate;
   logic           mem_debug;
   logic [1:0]     debug_func;
   logic           debug_we;
   logic           debug_re;
   mpa_pkg::word_t addr;
   mpa_pkg::word_t din;
   mpa_pkg::word_t dout;

   int checks;
   int errors;

   mpa_core_top dut_i (
      .HW_RSTn            (HW_RSTn),
      .mem_debug_clk_gate (mem_debug_clk_gate),
      .mem_debug          (mem_debug),
      .debug_func         (debug_func),
      .debug_we           (debug_we),
      .debug_re           (debug_re),
      .addr               (addr),
      .din                (din),
      .dout               (dout)
   );

   initial begin
      mem_debug_clk_gate = 1'b0;
      forever #(CLK_PERIOD / 2) mem_debug_clk_gate = ~mem_debug_clk_gate;
   end

   // One halted write, strobe sampled on the next rising edge
   task automatic backdoor_write(input logic [1:0] tgt, input mpa_pkg::word_t a,
                                 input mpa_pkg::word_t d);
      mem_debug  = 1'b1;
      debug_func = tgt;
      addr       = a;
      din        = d;
      debug_we   = 1'b1;
      @(negedge mem_debug_clk_gate);
      debug_we   = 1'b0;
      debug_func = 2'd0;
   endtask

   // Halted read, dout valid one edge later
   task automatic read_check(input logic [1:0] tgt, input mpa_pkg::word_t a,
                             input mpa_pkg::word_t exp);
      int n;
      mem_debug  = 1'b1;
      debug_func = tgt;
      addr       = a;
      debug_re   = 1'b1;
      for (n = 0; n < READ_LAT; n++) begin
         @(negedge mem_debug_clk_gate);
      end
      debug_re   = 1'b0;
      debug_func = 2'd0;
      checks++;
      assert (dout === exp) else begin
         errors++;
         $display("Error at %0t: target %0d addr %h expected %h seen %h",
                  $time, tgt, a, exp, dout);
      end
   endtask

   // Core retires one instruction per rising edge while mem_debug is low
   task automatic run_core(input int cycles);
      int n;
      assert (cycles <= MAX_RUN) else begin
         errors++;
         $display("Run of %0d cycles is longer than the limit of %0d", cycles, MAX_RUN);
      end
      mem_debug = 1'b0;
      for (n = 0; n < cycles && n < MAX_RUN; n++) begin
         @(negedge mem_debug_clk_gate);
      end
      mem_debug = 1'b1;
   endtask

   // Comment runs to end of line
   task automatic skip_line(input int fd);
      int c;
      int n;
      c = 0;
      for (n = 0; n < MAX_CHARS && c != "\n" && c != -1; n++) begin
         c = $fgetc(fd);
      end
   endtask

   // Case file record must carry all its fields
   task automatic fields_check(input int got, input int want);
      assert (got == want) else begin
         errors++;
         $display("Case file record has %0d fields where %0d were expected", got, want);
      end
   endtask

   initial begin
      int             fd;
      int             c;
      int             steps;
      int             got;
      int             cycles;
      int             n;
      logic [1:0]     tgt;
      mpa_pkg::word_t a;
      mpa_pkg::word_t d;

      checks     = 0;
      errors     = 0;
      steps      = 0;
      HW_RSTn    = 1'b0;
      mem_debug  = 1'b1;
      debug_func = 2'd0;
      debug_we   = 1'b0;
      debug_re   = 1'b0;
      addr       = '0;
      din        = '0;

      // Reset across two rising edges
      for (n = 0; n < 2; n++) begin
         @(negedge mem_debug_clk_gate);
      end
      HW_RSTn = 1'b1;
      @(negedge mem_debug_clk_gate);

      fd = $fopen("tb/mpa_cases.txt", "r");
      assert (fd != 0) else begin
         errors++;
         $display("Could not open the case file tb/mpa_cases.txt");
      end
      if (fd != 0) begin
         c = $fgetc(fd);
         while (c != -1 && steps < MAX_STEPS) begin
            steps++;
            case (c)
               "#": skip_line(fd);
               "W": begin
                  got = $fscanf(fd, " %h %h %h", tgt, a, d);
                  fields_check(got, 3);
                  backdoor_write(tgt, a, d);
               end
               "C": begin
                  got = $fscanf(fd, " %h %h %h", tgt, a, d);
                  fields_check(got, 3);
                  read_check(tgt, a, d);
               end
               "R": begin
                  got = $fscanf(fd, " %d", cycles);
                  fields_check(got, 1);
                  run_core(cycles);
               end
               default: begin
                  // Anything but whitespace is a broken record
                  if (c > 32) begin
                     errors++;
                     $display("Unknown record type in the case file");
                  end
               end
            endcase
            c = $fgetc(fd);
         end
         if (c != -1) begin
            errors++;
            $display("Case file was not finished within %0d steps", MAX_STEPS);
         end
         $fclose(fd);
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Watchdog over the whole run
   initial begin
      int n;
      for (n = 0; n < MAX_CYCLES; n++) begin
         @(posedge mem_debug_clk_gate);
      end
      $display("Timeout: simulation did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
   end

endmodule

// ==== compile.f ====
verilog/mpa_pkg.sv
verilog/mpa_debug_if.sv
verilog/mpa_debug_port.sv
verilog/mpa_fetch.sv
verilog/mpa_decoder.sv
verilog/mpa_reg_file.sv
verilog/mpa_alu.sv
verilog/mpa_data_mem.sv
verilog/mpa_core_top.sv
tb/mpa_tb.sv

// ==== tb/mpa_cases.txt ====
# W tgt addr data: back-door write; tgt 1 imem (word index), 2 dmem (byte addr), 3 regs
# R cycles: run the core; C tgt addr expected: back-door read-back check
W 3 00000001 12345678
W 3 00000002 0f0f0f0f
W 3 00000009 0000ffff
W 3 0000000a 5a5a5a5a
W 3 0000000b 00000010
W 3 0000001f 87654321
W 3 00000000 ffffffff
C 3 0000001f 87654321
C 3 00000000 00000000
W 2 00000000 11223344
W 2 00000010 deadbeef
W 2 00000014 8badf00d
C 2 00000010 deadbeef
C 2 00000014 8badf00d
# Program: ADDU SUBU AND OR XOR NOR, LUI, no-op, LW LHU LBU LBU(-13), dependent ADDU
W 1 00000000 00221821
W 1 00000001 00222023
W 1 00000002 00222824
W 1 00000003 00223025
W 1 00000004 00223826
W 1 00000005 00224027
W 1 00000006 3c09abcd
W 1 00000007 00000000
W 1 00000008 8d6c0004
W 1 00000009 956d0006
W 1 0000000a 916e0001
W 1 0000000b 916ffff3
W 1 0000000c 006c8021
# Sentinel after the program, would overwrite r10 if it retired
W 1 0000000d 00225021
C 1 00000006 3c09abcd
C 1 0000000d 00225021
R 13
C 3 00000003 21436587
C 3 00000004 03254769
C 3 00000005 02040608
C 3 00000006 1f3f5f7f
C 3 00000007 1d3b5977
C 3 00000008 e0c0a080
C 3 00000009 abcd0000
C 3 0000000c 8badf00d
C 3 0000000d 00008bad
C 3 0000000e 000000be
C 3 0000000f 00000011
C 3 00000010 acf15594
C 3 00000001 12345678
C 3 00000002 0f0f0f0f
C 3 0000000a 5a5a5a5a
C 3 0000000b 00000010
C 3 0000001f 87654321
C 3 00000000 00000000
